// File: Makefile
TOP := pkt_steer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: source/dest_apply.sv
`timescale 1ns/100ps

module dest_apply (
   input  logic                                  core_clk,
   input  logic                                  rst_n,
   input  logic                                  advance,
   input  pkt_steer_pkg::stage_t                 s2,
   input  pkt_steer_pkg::route_t                 r2,
   output pkt_steer_pkg::beat_t                  out_beat,
   output logic                                  out_valid,
   output logic [pkt_steer_pkg::port_w-1:0]      out_dest,
   output logic [pkt_steer_pkg::ts_w-1:0]        out_ts,
   output logic [pkt_steer_pkg::cnt_w-1:0]       pkt_count,
   output logic [pkt_steer_pkg::cnt_w-1:0]       miss_count
);

   import pkt_steer_pkg::*;

   // Route held for the beats after the first
   route_t route_hold;

   // Route applied to the beat in stage 2
   route_t cur_route;

   // Side info on the output beat
   logic   out_sop_q;
   logic   out_hit_q;

   // Output beat leaves this cycle
   logic   out_take;

   // ----------------------------------------------------------------------
   // Route latch
   // ----------------------------------------------------------------------

   // Route of the current packet kept for its later beats
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         route_hold <= '0;
      end else if (advance && s2.valid && s2.sop) begin
         route_hold <= r2;
      end
   end

   // Fresh lookup on the first beat and the held copy afterwards
   assign cur_route = s2.sop ? r2 : route_hold;

   // ----------------------------------------------------------------------
   // Output register
   // ----------------------------------------------------------------------

   // Control part
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         out_sop_q <= 1'b0;
      end else if (advance) begin
         out_valid <= s2.valid;
         out_sop_q <= s2.sop;
      end
   end

   // Payload part
   always_ff @(posedge core_clk) begin
      if (advance) begin
         out_beat  <= s2.beat;
         out_dest  <= cur_route.dest;
         out_hit_q <= cur_route.hit;
         out_ts    <= s2.ts;
      end
   end

   // ----------------------------------------------------------------------
   // Statistics
   // ----------------------------------------------------------------------

   // Sink takes the beat when out_ready is high
   assign out_take = out_valid && advance;

   // One count per packet as its first beat leaves
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_count  <= '0;
         miss_count <= '0;
      end else if (out_take && out_sop_q) begin
         pkt_count <= pkt_count + cnt_w'(1);
         if (!out_hit_q) begin
            miss_count <= miss_count + cnt_w'(1);
         end
      end
   end

   // Dest only changes on a first beat even across stalls and bubbles
   a_dest_stable : assert property (
      @(posedge core_clk) disable iff (!rst_n)
      (out_valid && !out_sop_q) |-> $stable(out_dest)
   ) else $error("dest_apply: out_dest changed inside a packet");

endmodule

// File: source/frame_parser.sv
`timescale 1ns/100ps

module frame_parser (
   input  logic                           core_clk,
   input  logic                           rst_n,
   input  pkt_steer_pkg::beat_t           in_beat,
   input  logic                           in_valid,
   output logic                           in_ready,
   input  logic [pkt_steer_pkg::ts_w-1:0] timestamp,
   input  logic                           advance,
   input  logic                           pause,
   output pkt_steer_pkg::stage_t          s1
);

   import pkt_steer_pkg::*;

   // Handshake
   logic             accept;

   // Start of packet tracking
   logic             sop_flag;

   // Per-packet values held for the beats after the first
   logic [tag_w-1:0] tag_hold;
   logic [ts_w-1:0]  ts_hold;

   // Tag and timestamp that go with the current input beat
   logic [tag_w-1:0] beat_tag;
   logic [ts_w-1:0]  beat_ts;

   // ----------------------------------------------------------------------
   // Input handshake
   // ----------------------------------------------------------------------

   // Pause blocks new input while the pipe keeps draining
   assign in_ready = advance && !pause;
   assign accept   = in_valid && in_ready;

   // ----------------------------------------------------------------------
   // Packet framing
   // ----------------------------------------------------------------------

   // Next accepted beat opens a packet once the last one closed
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         sop_flag <= 1'b1;
      end else if (accept) begin
         sop_flag <= in_beat.last;
      end
   end

   // Capture tag and ingress time on the first beat only
   always_ff @(posedge core_clk) begin
      if (accept && sop_flag) begin
         tag_hold <= in_beat.data[data_w-1 -: tag_w];
         ts_hold  <= timestamp;
      end
   end

   // First beat uses the live values and later beats the held ones
   assign beat_tag = sop_flag ? in_beat.data[data_w-1 -: tag_w] : tag_hold;
   assign beat_ts  = sop_flag ? timestamp : ts_hold;

   // ----------------------------------------------------------------------
   // Stage 1 register
   // ----------------------------------------------------------------------

   // Moves with the rest of the pipe and carries a bubble when nothing is accepted
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         s1 <= '0;
      end else if (advance) begin
         s1.valid <= accept;
         s1.sop   <= sop_flag;
         s1.beat  <= in_beat;
         s1.tag   <= beat_tag;
         s1.ts    <= beat_ts;
      end
   end

   // Framing depends on last, so an X here would corrupt every later packet
   a_last_known : assert property (
      @(posedge core_clk) disable iff (!rst_n)
      in_valid |-> !$isunknown(in_beat.last)
   ) else $error("frame_parser: in_valid with unknown last flag");

endmodule

// File: source/pkt_steer_pkg.sv
package pkt_steer_pkg;

   // ----------------------------------------------------------------------
   // Stream geometry
   // ----------------------------------------------------------------------

   // One 64-bit beat with a byte enable per byte
   localparam int data_w = 64;
   localparam int keep_w = 8;

   // Packet tag sits in the top byte of the first beat
   localparam int tag_w = 8;

   // Free-running ingress timestamp
   localparam int ts_w = 48;

   // Packet and miss counters
   localparam int cnt_w = 16;

   // ----------------------------------------------------------------------
   // Route table
   // ----------------------------------------------------------------------

   // Low tag bits index the table
   localparam int table_depth = 16;
   localparam int idx_w       = $clog2(table_depth);

   // Destination port field
   localparam int port_w = 2;

   // ----------------------------------------------------------------------
   // Configuration strobe port
   // ----------------------------------------------------------------------

   localparam int cfg_addr_w = 5;
   localparam int cfg_data_w = 8;

   // Addresses 0..15 are table entries, then two registers
   localparam int cfg_addr_default = 16;
   localparam int cfg_addr_ctrl    = 17;

   // Entry layout in wdata is valid on bit 2 and port on bits 1:0
   localparam int entry_valid_bit = 2;

   // Control register bits
   localparam int ctrl_pause_bit = 0;

   // One stream beat
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [keep_w-1:0] keep;
      logic              last;
   } beat_t;

   // Pipeline register carried between stages
   typedef struct packed {
      logic             valid;
      logic             sop;
      beat_t            beat;
      logic [tag_w-1:0] tag;
      logic [ts_w-1:0]  ts;
   } stage_t;

   // Result of a table lookup
   typedef struct packed {
      logic [port_w-1:0] dest;
      logic              hit;
   } route_t;

   // Single-cycle configuration write
   typedef struct packed {
      logic                  wr;
      logic [cfg_addr_w-1:0] addr;
      logic [cfg_data_w-1:0] wdata;
   } cfg_t;

endpackage

// File: source/pkt_steer_top.sv
`timescale 1ns/100ps

module pkt_steer_top (
   input  logic                           core_clk,
   input  logic                           rst_n,

   // Input stream
   input  pkt_steer_pkg::beat_t           in_beat,
   input  logic                           in_valid,
   output logic                           in_ready,

   // Output stream
   output pkt_steer_pkg::beat_t           out_beat,
   output logic [pkt_steer_pkg::port_w-1:0] out_dest,
   output logic [pkt_steer_pkg::ts_w-1:0] out_ts,
   output logic                           out_valid,
   input  logic                           out_ready,

   // Configuration and status
   input  pkt_steer_pkg::cfg_t            cfg,
   input  logic [pkt_steer_pkg::ts_w-1:0] timestamp,
   output logic [pkt_steer_pkg::cnt_w-1:0] pkt_count,
   output logic [pkt_steer_pkg::cnt_w-1:0] miss_count
);

   import pkt_steer_pkg::*;

   // Stage registers between blocks
   stage_t s1;
   stage_t s2;
   route_t r2;

   // Pause level from the control register
   logic   pause;

   // Whole pipe steps on out_ready
   logic   advance;

   assign advance = out_ready;

   // ----------------------------------------------------------------------
   // Stage 1 parse and timestamp
   // ----------------------------------------------------------------------
   frame_parser frame_parser_i (
      .core_clk  (core_clk),
      .rst_n     (rst_n),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .timestamp (timestamp),
      .advance   (advance),
      .pause     (pause),
      .s1        (s1)
   );

   // ----------------------------------------------------------------------
   // Stage 2 table lookup
   // ----------------------------------------------------------------------
   route_table route_table_i (
      .core_clk (core_clk),
      .rst_n    (rst_n),
      .cfg      (cfg),
      .advance  (advance),
      .s1       (s1),
      .pause    (pause),
      .s2       (s2),
      .r2       (r2)
   );

   // ----------------------------------------------------------------------
   // Stage 3 apply dest and count
   // ----------------------------------------------------------------------
   dest_apply dest_apply_i (
      .core_clk   (core_clk),
      .rst_n      (rst_n),
      .advance    (advance),
      .s2         (s2),
      .r2         (r2),
      .out_beat   (out_beat),
      .out_valid  (out_valid),
      .out_dest   (out_dest),
      .out_ts     (out_ts),
      .pkt_count  (pkt_count),
      .miss_count (miss_count)
   );

endmodule

// File: source/route_table.sv
`timescale 1ns/100ps

module route_table (
   input  logic                  core_clk,
   input  logic                  rst_n,
   input  pkt_steer_pkg::cfg_t   cfg,
   input  logic                  advance,
   input  pkt_steer_pkg::stage_t s1,
   output logic                  pause,
   output pkt_steer_pkg::stage_t s2,
   output pkt_steer_pkg::route_t r2
);

   import pkt_steer_pkg::*;

   // Table storage as valid bits and port fields
   logic [table_depth-1:0]             entry_valid;
   logic [table_depth-1:0][port_w-1:0] entry_port;

   // Miss target and control register
   logic [port_w-1:0]                  default_port;
   logic                               pause_q;

   // Config decode
   logic                               cfg_table_wr;
   logic [idx_w-1:0]                   cfg_idx;

   // Lookup path
   logic [idx_w-1:0]                   lookup_idx;
   route_t                             lookup;

   // ----------------------------------------------------------------------
   // Configuration writes
   // ----------------------------------------------------------------------

   // Addresses below table_depth hit a table entry
   assign cfg_table_wr = cfg.wr && (cfg.addr < cfg_addr_w'(table_depth));
   assign cfg_idx      = cfg.addr[idx_w-1:0];

   // Valid bits, default port and pause
   // Anything above the control address falls through untouched
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid  <= '0;
         default_port <= '0;
         pause_q      <= 1'b0;
      end else if (cfg.wr) begin
         if (cfg_table_wr) begin
            entry_valid[cfg_idx] <= cfg.wdata[entry_valid_bit];
         end else if (cfg.addr == cfg_addr_w'(cfg_addr_default)) begin
            default_port <= cfg.wdata[port_w-1:0];
         end else if (cfg.addr == cfg_addr_w'(cfg_addr_ctrl)) begin
            pause_q <= cfg.wdata[ctrl_pause_bit];
         end
      end
   end

   // Port field of each entry
   always_ff @(posedge core_clk) begin
      if (cfg_table_wr) begin
         entry_port[cfg_idx] <= cfg.wdata[port_w-1:0];
      end
   end

   // Level to the parser
   assign pause = pause_q;

   // ----------------------------------------------------------------------
   // Lookup
   // ----------------------------------------------------------------------

   // Low tag bits select the entry
   assign lookup_idx = s1.tag[idx_w-1:0];

   // Valid entry gives its port and a miss falls back to default
   always_comb begin
      if (entry_valid[lookup_idx]) begin
         lookup.dest = entry_port[lookup_idx];
         lookup.hit  = 1'b1;
      end else begin
         lookup.dest = default_port;
         lookup.hit  = 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // Stage 2 register
   // ----------------------------------------------------------------------

   // Route only reloads on a real first beat
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         s2 <= '0;
         r2 <= '0;
      end else if (advance) begin
         s2 <= s1;
         if (s1.valid && s1.sop) begin
            r2 <= lookup;
         end
      end
   end

   // Out-of-range write leaves every reset-visible register as it was
   a_cfg_range : assert property (
      @(posedge core_clk) disable iff (!rst_n)
      (cfg.wr && (cfg.addr > cfg_addr_w'(cfg_addr_ctrl))) |=>
         ($stable(entry_valid) && $stable(default_port) && $stable(pause_q))
   ) else $error("route_table: out-of-range config write changed state");

endmodule

// File: verif/pkt_steer_tb.sv
`timescale 1ns/100ps

module pkt_steer_tb;

   import pkt_steer_pkg::*;

   // Row kinds of the stimulus table
   localparam logic [1:0] k_cfg  = 2'd0;
   localparam logic [1:0] k_pkt  = 2'd1;
   localparam logic [1:0] k_hold = 2'd2;
   localparam logic [1:0] k_cnt  = 2'd3;
   localparam int         n_rows = 31;

   // One stimulus row
   // For a hold row nbeats counts cycles
   typedef struct packed {
      logic [1:0]            kind;
      logic [2:0]            test;
      logic [cfg_addr_w-1:0] addr;
      logic [cfg_data_w-1:0] wdata;
      logic [tag_w-1:0]      tag;
      logic [7:0]            nbeats;
      logic [port_w-1:0]     dest;
      logic                  hit;
      logic                  stall;
   } row_t;

   // Scoreboard entry for one output beat
   typedef struct packed {
      beat_t             beat;
      logic [port_w-1:0] dest;
      logic [ts_w-1:0]   ts;
   } exp_t;

   // DUT ports
   logic core_clk, rst_n, in_valid, in_ready, out_valid, out_ready;
   beat_t in_beat, out_beat;
   logic [port_w-1:0] out_dest;
   logic [ts_w-1:0] out_ts, timestamp, ts_now;
   cfg_t cfg, cfg_next;
   logic [cnt_w-1:0] pkt_count, miss_count, exp_pkts, exp_miss;

   // Route table model
   logic [table_depth-1:0] model_valid;
   logic [port_w-1:0]      model_port [table_depth];
   logic [port_w-1:0]      model_default;

   exp_t exp_q [$];
   logic stall_en;
   int   errors, pass_tests, fail_tests, cycle_count, cycle_limit;

   // kind, test, addr, wdata, tag, nbeats, dest, hit, stall
   row_t table_rows [n_rows] = '{
      '{k_pkt,  3'd1, 5'd0,  8'h00, 8'h13, 8'd3, 2'd0, 1'b0, 1'b0},
      '{k_pkt,  3'd1, 5'd0,  8'h00, 8'h2a, 8'd1, 2'd0, 1'b0, 1'b0},
      '{k_pkt,  3'd1, 5'd0,  8'h00, 8'h7f, 8'd2, 2'd0, 1'b0, 1'b0},
      '{k_cnt,  3'd1, 5'd0,  8'h00, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd2, 5'd3,  8'h05, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd2, 5'd10, 8'h07, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd2, 5'd4,  8'h06, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_pkt,  3'd2, 5'd0,  8'h00, 8'ha3, 8'd4, 2'd1, 1'b1, 1'b0},
      '{k_pkt,  3'd2, 5'd0,  8'h00, 8'h5a, 8'd2, 2'd3, 1'b1, 1'b0},
      '{k_pkt,  3'd2, 5'd0,  8'h00, 8'h04, 8'd1, 2'd2, 1'b1, 1'b0},
      '{k_cnt,  3'd2, 5'd0,  8'h00, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      // Default port 2, entry 10 invalid, address 20 must be ignored
      '{k_cfg,  3'd3, 5'd16, 8'h02, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd3, 5'd10, 8'h03, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd3, 5'd20, 8'h04, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_pkt,  3'd3, 5'd0,  8'h00, 8'h1a, 8'd3, 2'd2, 1'b0, 1'b0},
      '{k_pkt,  3'd3, 5'd0,  8'h00, 8'hf7, 8'd2, 2'd2, 1'b0, 1'b0},
      '{k_pkt,  3'd3, 5'd0,  8'h00, 8'h84, 8'd1, 2'd2, 1'b1, 1'b0},
      '{k_cnt,  3'd3, 5'd0,  8'h00, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_pkt,  3'd4, 5'd0,  8'h00, 8'h63, 8'd6, 2'd1, 1'b1, 1'b0},
      '{k_pkt,  3'd4, 5'd0,  8'h00, 8'he4, 8'd3, 2'd2, 1'b1, 1'b0},
      '{k_pkt,  3'd5, 5'd0,  8'h00, 8'h44, 8'd5, 2'd2, 1'b1, 1'b1},
      '{k_pkt,  3'd5, 5'd0,  8'h00, 8'h0a, 8'd1, 2'd2, 1'b0, 1'b1},
      '{k_pkt,  3'd5, 5'd0,  8'h00, 8'hc3, 8'd3, 2'd1, 1'b1, 1'b1},
      '{k_pkt,  3'd5, 5'd0,  8'h00, 8'h9a, 8'd4, 2'd2, 1'b0, 1'b1},
      '{k_cnt,  3'd5, 5'd0,  8'h00, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd6, 5'd17, 8'h01, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_hold, 3'd6, 5'd0,  8'h00, 8'h23, 8'd8, 2'd0, 1'b0, 1'b0},
      '{k_cfg,  3'd6, 5'd17, 8'h00, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0},
      '{k_pkt,  3'd6, 5'd0,  8'h00, 8'h23, 8'd2, 2'd1, 1'b1, 1'b1},
      '{k_pkt,  3'd6, 5'd0,  8'h00, 8'h5a, 8'd1, 2'd2, 1'b0, 1'b1},
      '{k_cnt,  3'd6, 5'd0,  8'h00, 8'h00, 8'd0, 2'd0, 1'b0, 1'b0}
   };

   pkt_steer_top pkt_steer_top_i (.*);

   // ----------------------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------------------

   task automatic check_beat(input beat_t act, input beat_t exp_b);
      if (act !== exp_b) begin
         errors++;
         $display("ERROR at %0t: beat %h/%h/%b, expected %h/%h/%b", $time,
                  act.data, act.keep, act.last, exp_b.data, exp_b.keep, exp_b.last);
      end
   endtask

   task automatic check_route(input logic [port_w-1:0] dest, input logic [ts_w-1:0] ts,
                              input logic [port_w-1:0] exp_dest, input logic [ts_w-1:0] exp_ts);
      if (dest !== exp_dest || ts !== exp_ts) begin
         errors++;
         $display("ERROR at %0t: dest %0d ts %h, expected dest %0d ts %h", $time,
                  dest, ts, exp_dest, exp_ts);
      end
   endtask

   task automatic check_count(input logic [cnt_w-1:0] act, input logic [cnt_w-1:0] exp_c,
                              input string name);
      if (act !== exp_c) begin
         errors++;
         $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, act, exp_c);
      end
   endtask

   // ----------------------------------------------------------------------
   // Cycle driver and row handlers
   // ----------------------------------------------------------------------

   // Drive on the falling edge, then look at the settled outputs
   task automatic run_cycle(input logic valid, input beat_t beat, output logic taken);
      exp_t exp_e;
      @(negedge core_clk);
      in_valid  = valid;
      in_beat   = beat;
      cfg       = cfg_next;
      out_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
      ts_now    = ts_now + 48'd3;
      timestamp = ts_now;
      #1;
      // Output transfer happens at the coming rising edge
      if (out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: output beat with no beat expected", $time);
         end else begin
            exp_e = exp_q.pop_front();
            check_beat(out_beat, exp_e.beat);
            check_route(out_dest, out_ts, exp_e.dest, exp_e.ts);
         end
      end
      taken = valid && in_ready;
   endtask

   // Empty the pipe and give the counters one more edge
   task automatic drain();
      logic taken;
      while (exp_q.size() != 0) begin
         run_cycle(1'b0, '0, taken);
      end
      run_cycle(1'b0, '0, taken);
   endtask

   task automatic write_cfg(input row_t row);
      logic taken;
      drain();
      cfg_next = '{wr: 1'b1, addr: row.addr, wdata: row.wdata};
      run_cycle(1'b0, '0, taken);
      cfg_next = '0;
      run_cycle(1'b0, '0, taken);
      // Model follows the address map and ignores anything above ctrl
      if (row.addr < cfg_addr_w'(table_depth)) begin
         model_valid[row.addr[idx_w-1:0]] = row.wdata[entry_valid_bit];
         model_port[row.addr[idx_w-1:0]]  = row.wdata[port_w-1:0];
      end else if (row.addr == cfg_addr_w'(cfg_addr_default)) begin
         model_default = row.wdata[port_w-1:0];
      end
   endtask

   task automatic send_packet(input row_t row);
      beat_t             beat;
      exp_t              exp_e;
      logic              taken;
      logic              hit;
      logic [port_w-1:0] dest;
      logic [ts_w-1:0]   pkt_ts;
      hit    = model_valid[row.tag[idx_w-1:0]];
      dest   = hit ? model_port[row.tag[idx_w-1:0]] : model_default;
      pkt_ts = '0;
      if (hit != row.hit || dest != row.dest) begin
         errors++;
         $display("ERROR at %0t: row for tag %h disagrees with route model", $time, row.tag);
      end
      for (int i = 0; i < int'(row.nbeats); i++) begin
         beat.data = {$urandom, $urandom};
         if (i == 0) begin
            beat.data[data_w-1 -: tag_w] = row.tag;
         end
         beat.last = (i == int'(row.nbeats) - 1);
         beat.keep = beat.last ? (8'hff >> ($urandom % 8)) : 8'hff;
         taken = 1'b0;
         while (!taken) begin
            run_cycle(1'b1, beat, taken);
         end
         // Ingress time is the value driven when the first beat went in
         if (i == 0) begin
            pkt_ts = ts_now;
         end
         exp_e.beat = beat;
         exp_e.dest = dest;
         exp_e.ts   = pkt_ts;
         exp_q.push_back(exp_e);
      end
      exp_pkts = exp_pkts + 16'd1;
      if (!hit) begin
         exp_miss = exp_miss + 16'd1;
      end
   endtask

   // Offer a beat while paused, none may be taken
   task automatic hold_paused(input row_t row);
      beat_t beat;
      logic  taken;
      beat = '{data: {row.tag, 56'h0}, keep: 8'hff, last: 1'b1};
      for (int i = 0; i < int'(row.nbeats); i++) begin
         run_cycle(1'b1, beat, taken);
         if (in_ready || taken) begin
            errors++;
            $display("ERROR at %0t: in_ready high while paused", $time);
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Clock, timeout and main sequence
   // ----------------------------------------------------------------------

   initial begin
      core_clk = 1'b0;
      forever #50 core_clk = ~core_clk;
   end

   initial begin
      @(posedge core_clk);
      while (cycle_count < cycle_limit) begin
         @(posedge core_clk);
         cycle_count++;
      end
      $display("Timeout: stimulus still running after %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
   end

   initial begin
      int   err_before;
      logic taken;
      void'($urandom(32'h8dd6));
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_beat = '0;
      out_ready = 1'b0;
      cfg = '0;
      cfg_next = '0;
      ts_now = {16'h0, $urandom};
      timestamp = ts_now;
      stall_en = 1'b0;
      model_valid = '0;
      model_default = '0;
      foreach (model_port[i]) model_port[i] = '0;
      exp_pkts = '0;
      exp_miss = '0;
      cycle_count = 0;
      cycle_limit = 200;
      foreach (table_rows[i]) cycle_limit += 20 * int'(table_rows[i].nbeats);
      repeat (2) @(negedge core_clk);
      rst_n = 1'b1;

      // After reset nothing is valid and in_ready follows out_ready
      err_before = errors;
      run_cycle(1'b0, '0, taken);
      if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
         errors++;
         $display("ERROR at %0t: out_valid or in_ready wrong after reset", $time);
      end
      check_count(pkt_count, '0, "pkt_count");
      check_count(miss_count, '0, "miss_count");

      for (int r = 0; r < n_rows; r++) begin
         stall_en = table_rows[r].stall;
         case (table_rows[r].kind)
            k_cfg:   write_cfg(table_rows[r]);
            k_pkt:   send_packet(table_rows[r]);
            k_hold:  hold_paused(table_rows[r]);
            default: begin
               drain();
               check_count(pkt_count, exp_pkts, "pkt_count");
               check_count(miss_count, exp_miss, "miss_count");
            end
         endcase
         // One result line as the last row of each test finishes
         if (r == n_rows - 1 || table_rows[r + 1].test != table_rows[r].test) begin
            if (errors == err_before) pass_tests++;
            else fail_tests++;
            $display("Test %0d: %s", table_rows[r].test,
                     errors == err_before ? "pass" : "FAIL");
            err_before = errors;
         end
      end

      $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
      if (fail_tests == 0 && errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
source/pkt_steer_pkg.sv
source/frame_parser.sv
source/route_table.sv
source/dest_apply.sv
source/pkt_steer_top.sv
verif/pkt_steer_tb.sv
